/* sources.f */
+incdir+.
cam_pkg.sv
ccd_capture.sv
bayer_to_rgb.sv
hex_display.sv
camera_top.sv
tb_camera.sv

/* run_sim.sh */
#!/bin/sh
# Build the camera testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_camera \
  --Mdir obj_dir -o tb_camera
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_camera
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
fi
exit $status

/* tb_camera_model.svh */
/*
  Reference model for the camera testbench. Gives the expected RGB
  pixel of one Bayer quad and the active-low pattern of one hex digit.
  Included inside the testbench module.
*/
`ifndef TB_CAMERA_MODEL_SVH
`define TB_CAMERA_MODEL_SVH

// Quad is G R over B G; ul and cur are the two greens
function automatic cam_pkg::rgb_pix_t quad_rgb(input cam_pkg::pixel_t ul,
                                               input cam_pkg::pixel_t up,
                                               input cam_pkg::pixel_t left,
                                               input cam_pkg::pixel_t cur);
  int                green_sum;  // Both greens as plain integers
  cam_pkg::rgb_pix_t res;
  green_sum = int'(ul) + int'(cur);
  res.valid = 1'b1;
  res.r     = up;                                // Red above
  res.g     = cam_pkg::pixel_t'(green_sum / 2);  // Mean, rounded down
  res.b     = left;                              // Blue to the left
  return res;
endfunction

// Active-low digit patterns 0 to F with segment g leftmost
function automatic cam_pkg::seg7_t seg_ref(input logic [3:0] nib);
  cam_pkg::seg7_t table_g2a [16];
  table_g2a = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
                7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};
  return table_g2a[nib];
endfunction

`endif

/* tb_camera.sv */
/*
  Testbench for camera_top. Drives 8x6 Bayer frames with random gaps,
  arms and disarms capture, and checks every RGB strobe and the
  frame count digits against the reference model.
*/
`default_nettype none

module tb_camera;

  localparam int CLK_PERIOD   = 40;
  localparam int FRAME_PIXELS = 8;
  localparam int FRAME_LINES  = 6;
  localparam int N_FRAMES     = 8;
  localparam int FRAME_CYCLES = FRAME_LINES * (FRAME_PIXELS + 5) + 10;  // Worst case
  localparam int WATCHDOG_CYCLES = N_FRAMES * (FRAME_CYCLES + 20) + 200;

  logic                 CLOCK_50;
  logic                 rst_n;
  cam_pkg::sensor_bus_t sensor;
  logic                 start;
  logic                 stop;
  cam_pkg::rgb_pix_t    rgb;
  cam_pkg::seg7_t       hex [cam_pkg::HEX_DIGITS];

  int                   seed;
  bit                   armed;       // Model of the capture rule
  cam_pkg::frame_cnt_t  exp_count;
  cam_pkg::rgb_pix_t    exp_q [$];   // Pending quads, raster order

  `include "tb_camera_model.svh"

  camera_top dut0 (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .sensor   (sensor),
    .start    (start),
    .stop     (stop),
    .rgb      (rgb),
    .hex0     (hex[0]),
    .hex1     (hex[1]),
    .hex2     (hex[2]),
    .hex3     (hex[3]),
    .hex4     (hex[4]),
    .hex5     (hex[5])
  );

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
  end

  // ========================================
  // Check tasks
  // ========================================
  task automatic check_rgb(input cam_pkg::rgb_pix_t exp, input cam_pkg::rgb_pix_t act);
    if ({act.r, act.g, act.b} !== {exp.r, exp.g, exp.b})
    begin
      $display("Fail rgb expected r=%h g=%h b=%h actual r=%h g=%h b=%h",
               exp.r, exp.g, exp.b, act.r, act.g, act.b);
      $display("Simulation failed");
      $fatal;
    end
  endtask

  task automatic check_seg(input int idx, input cam_pkg::seg7_t exp, input cam_pkg::seg7_t act);
    if (act !== exp)
    begin
      $display("Fail hex%0d expected %h actual %h", idx, exp, act);
      $display("Simulation failed");
      $fatal;
    end
  endtask

  task automatic check_digits();
    for (int i = 0; i < cam_pkg::HEX_DIGITS; i++)
      check_seg(i, seg_ref(exp_count[4*i +: 4]), hex[i]);
  endtask

  // ========================================
  // Stimulus helpers
  // ========================================
  // Holds one sample for one clock, pulses end with it
  task automatic drive_cycle(input logic fv, input logic lv, input cam_pkg::pixel_t d);
    sensor = '{fval: fv, lval: lv, data: d};
    @(posedge CLOCK_50);
    #5;
    start = 1'b0;
    stop  = 1'b0;
  endtask

  function automatic int rand_gap();
    return 2 + int'($unsigned($random(seed)) % 4);  // 2 to 5 cycles
  endfunction

  task automatic run_frame(input bit stop_mid);
    cam_pkg::pixel_t pix [FRAME_LINES][FRAME_PIXELS];
    int              gap;
    for (int y = 0; y < FRAME_LINES; y++)
      for (int x = 0; x < FRAME_PIXELS; x++)
        pix[y][x] = cam_pkg::pixel_t'($random(seed));
    if (armed)
    begin
      exp_count = exp_count + cam_pkg::frame_cnt_t'(1);
      for (int y = 1; y < FRAME_LINES; y += 2)
        for (int x = 1; x < FRAME_PIXELS; x += 2)
          exp_q.push_back(quad_rgb(pix[y-1][x-1], pix[y-1][x], pix[y][x-1], pix[y][x]));
    end
    for (int y = 0; y < FRAME_LINES; y++)
    begin
      for (int x = 0; x < FRAME_PIXELS; x++)
        drive_cycle(1'b1, 1'b1, pix[y][x]);
      if (y < FRAME_LINES - 1)
      begin
        gap = rand_gap();
        if (stop_mid && y == FRAME_LINES / 2)
          stop = 1'b1;  // Mid-frame stop, frame still completes
        repeat (gap) drive_cycle(1'b1, 1'b0, '0);
      end
    end
    if (stop_mid)
      armed = 1'b0;
    repeat (5) drive_cycle(1'b0, 1'b0, '0);
    check_digits();
    gap = rand_gap();
    repeat (gap) drive_cycle(1'b0, 1'b0, '0);
  endtask

  // ========================================
  // Compare process and watchdog
  // ========================================
  always @(negedge CLOCK_50)
  begin
    if (rst_n && rgb.valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error: rgb valid strobe with no expected pixel pending");
        $display("Simulation failed");
        $fatal;
      end
      else
        check_rgb(exp_q.pop_front(), rgb);
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog timeout, the run did not reach its end");
    $display("Simulation failed");
    $fatal;
  end

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin
    seed      = 54;
    rst_n     = 1'b0;
    sensor    = '0;
    start     = 1'b0;
    stop      = 1'b0;
    armed     = 1'b0;
    exp_count = '0;
    repeat (2) @(posedge CLOCK_50);
    #5;
    rst_n = 1'b1;
    repeat (3) drive_cycle(1'b0, 1'b0, '0);
    check_digits();  // All zero after reset
    run_frame(1'b0);  // Not armed yet
    start = 1'b1;
    drive_cycle(1'b0, 1'b0, '0);
    armed = 1'b1;
    repeat (3) run_frame(1'b0);
    run_frame(1'b1);  // Stop mid-frame
    run_frame(1'b0);  // Disarmed, nothing expected
    start = 1'b1;
    drive_cycle(1'b0, 1'b0, '0);
    armed = 1'b1;
    repeat (2) run_frame(1'b0);
    if (exp_q.size() != 0)
    begin
      $display("Error: %0d expected rgb pixels never came out", exp_q.size());
      $display("Simulation failed");
      $fatal;
    end
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* camera_top.sv */
/*
  Camera path top level. Registers the sensor bus once, then runs
  capture, Bayer demosaic and the frame count display.
*/
`default_nettype none

module camera_top (
  input  logic                 CLOCK_50,
  input  logic                 rst_n,
  input  cam_pkg::sensor_bus_t sensor,
  input  logic                 start,   // One-cycle arm pulse
  input  logic                 stop,    // One-cycle disarm pulse
  output cam_pkg::rgb_pix_t    rgb,
  output cam_pkg::seg7_t       hex0,
  output cam_pkg::seg7_t       hex1,
  output cam_pkg::seg7_t       hex2,
  output cam_pkg::seg7_t       hex3,
  output cam_pkg::seg7_t       hex4,
  output cam_pkg::seg7_t       hex5
);

  cam_pkg::sensor_bus_t sensor_q;     // Input register stage
  cam_pkg::bayer_pix_t  bayer_pix;
  cam_pkg::frame_cnt_t  frame_count;

  // ========================================
  // Sensor input register
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      sensor_q <= '0;  // No frame, no line
    else
      sensor_q <= sensor;
  end

  // ========================================
  // Pipeline
  // ========================================
  ccd_capture capture0 (
    .CLOCK_50    (CLOCK_50),
    .rst_n       (rst_n),
    .sensor      (sensor_q),
    .start       (start),
    .stop        (stop),
    .pix         (bayer_pix),
    .frame_count (frame_count)
  );

  bayer_to_rgb demosaic0 (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .pix      (bayer_pix),
    .rgb      (rgb)
  );

  // Count on six digits
  hex_display display0 (
    .frame_count (frame_count),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

endmodule

`default_nettype wire

/* hex_display.sv */
/*
  Frame count to six hex digits. Purely combinational; hex0 carries the
  least significant nibble, segments are active low.
*/
`default_nettype none

module hex_display (
  input  cam_pkg::frame_cnt_t frame_count,
  output cam_pkg::seg7_t      hex0,
  output cam_pkg::seg7_t      hex1,
  output cam_pkg::seg7_t      hex2,
  output cam_pkg::seg7_t      hex3,
  output cam_pkg::seg7_t      hex4,
  output cam_pkg::seg7_t      hex5
);

  cam_pkg::seg7_t seg [cam_pkg::HEX_DIGITS];

  // Active-low pattern, bit 0 is segment a
  function automatic cam_pkg::seg7_t nibble_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;  // Lower case b
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;  // Lower case d
      4'hE:    return 7'h06;
      default: return 7'h0E;  // F
    endcase
  endfunction

  // One nibble per digit
  always_comb
  begin
    for (int i = 0; i < cam_pkg::HEX_DIGITS; i++)
      seg[i] = nibble_to_seg(frame_count[4*i +: 4]);
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

`default_nettype wire

/* bayer_to_rgb.sv */
/*
  Bayer quad demosaic. A one-line buffer keeps the previous row; each
  pixel at odd column and odd row closes a 2x2 quad and yields one RGB
  pixel on the next cycle. Rows start G R on even y and B G on odd y.
*/
`default_nettype none

module bayer_to_rgb (
  input  logic                CLOCK_50,
  input  logic                rst_n,
  input  cam_pkg::bayer_pix_t pix,
  output cam_pkg::rgb_pix_t   rgb
);

  // Previous row, one entry per column
  cam_pkg::pixel_t                 line_mem [cam_pkg::LINE_PIXELS];
  logic [cam_pkg::LINE_ADDR_W-1:0] addr;
  cam_pkg::pixel_t                 up_pix;     // (x, y-1)
  cam_pkg::pixel_t                 up_left_q;  // (x-1, y-1)
  cam_pkg::pixel_t                 left_q;     // (x-1, y)
  logic                            quad_close;
  logic [cam_pkg::PIXEL_W:0]       g_sum;      // One extra bit for carry
  logic                            rgb_valid;
  cam_pkg::pixel_t                 r_q;
  cam_pkg::pixel_t                 g_q;
  cam_pkg::pixel_t                 b_q;

  // ========================================
  // Line buffer
  // ========================================
  assign addr   = pix.x[cam_pkg::LINE_ADDR_W-1:0];
  assign up_pix = line_mem[addr];  // Read before this row overwrites it

  always_ff @(posedge CLOCK_50)
  begin
    if (pix.valid)
      line_mem[addr] <= pix.data;
  end

  // Left neighbours in both rows
  always_ff @(posedge CLOCK_50)
  begin
    if (pix.valid)
    begin
      up_left_q <= up_pix;
      left_q    <= pix.data;
    end
  end

  // ========================================
  // Quad to RGB
  // ========================================
  assign quad_close = pix.valid & pix.x[0] & pix.y[0];  // Odd x on odd y

  // Two greens on the quad diagonal
  assign g_sum = {1'b0, up_left_q} + {1'b0, pix.data};

  always_ff @(posedge CLOCK_50)
  begin
    if (quad_close)
    begin
      r_q <= up_pix;                       // R sits above
      g_q <= g_sum[cam_pkg::PIXEL_W:1];    // Mean of both greens
      b_q <= left_q;                       // B sits left
    end
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      rgb_valid <= 1'b0;
    else
      rgb_valid <= quad_close;  // One-cycle strobe per quad
  end

  assign rgb = '{valid: rgb_valid, r: r_q, g: g_q, b: b_q};

endmodule

`default_nettype wire

/* ccd_capture.sv */
/*
  Frame-gated capture of the registered sensor bus. Start and stop
  arm and disarm at frame boundaries; captured pixels leave tagged with
  column and row one cycle later, and captured frames are counted.
*/
`default_nettype none

module ccd_capture (
  input  logic                 CLOCK_50,
  input  logic                 rst_n,
  input  cam_pkg::sensor_bus_t sensor,
  input  logic                 start,
  input  logic                 stop,
  output cam_pkg::bayer_pix_t  pix,
  output cam_pkg::frame_cnt_t  frame_count
);

  cam_pkg::capture_state_t state;
  cam_pkg::capture_state_t state_nxt;
  logic                    fval_d;      // Previous fval
  logic                    lval_d;      // Previous lval
  logic                    frame_rise;
  logic                    line_fall;
  logic                    cap_frame;   // This sample belongs to a captured frame
  logic                    cap_pix;
  cam_pkg::coord_t         x_cnt;       // Next column index
  cam_pkg::coord_t         y_cnt;       // Completed lines
  cam_pkg::frame_cnt_t     frame_cnt;
  logic                    pix_valid;
  cam_pkg::coord_t         pix_x;
  cam_pkg::coord_t         pix_y;
  cam_pkg::pixel_t         pix_data;

  // ========================================
  // Edge detect and gating
  // ========================================
  assign frame_rise = sensor.fval & ~fval_d;
  assign line_fall  = lval_d & ~sensor.lval;

  // Armed at the rise cycle counts as captured
  assign cap_frame = (state == cam_pkg::CAP_FRAME) || (state == cam_pkg::CAP_LAST) ||
                     ((state == cam_pkg::CAP_ARMED) && frame_rise);
  assign cap_pix   = cap_frame & sensor.fval & sensor.lval;

  // ========================================
  // Capture FSM
  // ========================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      cam_pkg::CAP_STOPPED:
        if (start)
          state_nxt = cam_pkg::CAP_ARMED;
      cam_pkg::CAP_ARMED:
        if (frame_rise)
          state_nxt = stop ? cam_pkg::CAP_LAST : cam_pkg::CAP_FRAME;  // Frame taken anyway
        else if (stop)
          state_nxt = cam_pkg::CAP_STOPPED;                           // Outside frame
      cam_pkg::CAP_FRAME:
        if (!sensor.fval)
          state_nxt = stop ? cam_pkg::CAP_STOPPED : cam_pkg::CAP_ARMED;
        else if (stop)
          state_nxt = cam_pkg::CAP_LAST;   // Let this frame finish
      cam_pkg::CAP_LAST:
        if (!sensor.fval)
          state_nxt = start ? cam_pkg::CAP_ARMED : cam_pkg::CAP_STOPPED;
        else if (start)
          state_nxt = cam_pkg::CAP_FRAME;  // Re-armed before frame end
      default:
        state_nxt = cam_pkg::CAP_STOPPED;
    endcase
  end

  // ========================================
  // Control registers and counters
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= cam_pkg::CAP_STOPPED;
      fval_d    <= 1'b0;
      lval_d    <= 1'b0;
      x_cnt     <= '0;
      y_cnt     <= '0;
      frame_cnt <= '0;
      pix_valid <= 1'b0;
    end
    else
    begin
      state     <= state_nxt;
      fval_d    <= sensor.fval;
      lval_d    <= sensor.lval;
      pix_valid <= cap_pix;
      if ((state == cam_pkg::CAP_ARMED) && frame_rise)
        frame_cnt <= frame_cnt + 1'b1;  // One per captured frame
      if (!sensor.fval)
      begin
        x_cnt <= '0;  // Idle between frames
        y_cnt <= '0;
      end
      else if (cap_pix)
        x_cnt <= x_cnt + 1'b1;
      else if (line_fall)
      begin
        x_cnt <= '0;
        if (cap_frame)
          y_cnt <= y_cnt + 1'b1;
      end
    end
  end

  // Pixel payload
  always_ff @(posedge CLOCK_50)
  begin
    if (cap_pix)
    begin
      pix_x    <= x_cnt;
      pix_y    <= y_cnt;
      pix_data <= sensor.data;
    end
  end

  assign pix         = '{valid: pix_valid, x: pix_x, y: pix_y, data: pix_data};
  assign frame_count = frame_cnt;

endmodule

`default_nettype wire

/* cam_pkg.sv */
/*
  Shared widths, vector types, bus structs and the capture FSM states
  of the camera path. Design files reach them by scoped names.
*/
`default_nettype none

package cam_pkg;

  // ========================================
  // Widths and sizes
  // ========================================
  localparam int PIXEL_W     = 12;   // Raw sample and each colour channel
  localparam int COORD_W     = 16;   // Column and row counters
  localparam int FRAME_CNT_W = 24;   // Six hex digits worth of frames
  localparam int LINE_PIXELS = 640;  // Longest supported line
  localparam int LINE_ADDR_W = $clog2(LINE_PIXELS);
  localparam int HEX_DIGITS  = 6;    // Digits on the board

  // ========================================
  // Vector types
  // ========================================
  typedef logic [PIXEL_W-1:0]     pixel_t;      // Raw sample or one channel
  typedef logic [COORD_W-1:0]     coord_t;      // Column or row index
  typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;  // Captured frame count

  // Active low, segment a in bit 0 up to g in bit 6
  typedef logic [6:0] seg7_t;

  // ========================================
  // Bus structs
  // ========================================
  // One sample from the sensor bus
  typedef struct packed {
    logic   fval;  // Frame valid
    logic   lval;  // Line valid
    pixel_t data;
  } sensor_bus_t;

  // One captured pixel with its position
  typedef struct packed {
    logic   valid;  // One-cycle strobe
    coord_t x;
    coord_t y;
    pixel_t data;
  } bayer_pix_t;

  // One demosaiced output pixel
  typedef struct packed {
    logic   valid;  // One-cycle strobe
    pixel_t r;
    pixel_t g;
    pixel_t b;
  } rgb_pix_t;

  // Capture FSM
  typedef enum logic [1:0] {
    CAP_STOPPED,  // Idle, no start seen
    CAP_ARMED,    // Waiting for next frame rise
    CAP_FRAME,    // Inside a captured frame
    CAP_LAST      // Captured frame, stop pending
  } capture_state_t;

endpackage

`default_nettype wire
